// File: files.f
source/vic_pkg.sv
source/vic_regs.sv
source/beam_counter.sv
source/pixel_sequencer.sv
source/vic_video_top.sv
sim/tb_vic_video_top.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --assert --timing --top-module tb_vic_video_top -f files.f -o tb_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" sim.log; then
    exit 0
fi

echo "pass message not found in sim.log"
exit 1

// File: sim/tb_vic_video_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_vic_video_top
    import vic_pkg::*;
();

    localparam int LINE_DOTS        = 64;
    localparam int LINE_COUNT       = 16;
    localparam int BORDER_LEFT      = 8;
    localparam int BORDER_RIGHT     = 56;
    localparam int BORDER_TOP       = 2;
    localparam int BORDER_BOTTOM    = 14;
    localparam int DATA_PIXEL_DELAY = 2;
    localparam int NUM_SCENARIOS    = 24;
    // two lines per scenario over a whole frame of clocks, plus room for the register sweep
    localparam int WATCHDOG_CLOCKS  = NUM_SCENARIOS * 2 * LINE_DOTS * LINE_COUNT * 4 + 20000;

    logic                        clk_dot4x;
    logic                        rst;
    logic [5:0]                  paddr;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [7:0]                  pwdata;
    logic [7:0]                  prdata;
    logic                        pready;
    logic                        pslverr;
    logic [7:0]                  pixels_read;
    logic [11:0]                 char_read;
    logic [NUM_SPRITES-1:0][1:0] sprite_pixels;
    vic_color_t                  pixel_color;
    logic                        is_background_pixel;
    logic [8:0]                  beam_x;
    logic [8:0]                  beam_y;

    int checks;
    int errors;

    vic_video_top #(
        .LINE_DOTS        (LINE_DOTS),
        .LINE_COUNT       (LINE_COUNT),
        .BORDER_LEFT      (BORDER_LEFT),
        .BORDER_RIGHT     (BORDER_RIGHT),
        .BORDER_TOP       (BORDER_TOP),
        .BORDER_BOTTOM    (BORDER_BOTTOM),
        .DATA_PIXEL_DELAY (DATA_PIXEL_DELAY)
    ) DUT (
        .clk_dot4x           (clk_dot4x),
        .rst                 (rst),
        .paddr               (paddr),
        .psel                (psel),
        .penable             (penable),
        .pwrite              (pwrite),
        .pwdata              (pwdata),
        .prdata              (prdata),
        .pready              (pready),
        .pslverr             (pslverr),
        .pixels_read         (pixels_read),
        .char_read           (char_read),
        .sprite_pixels       (sprite_pixels),
        .pixel_color         (pixel_color),
        .is_background_pixel (is_background_pixel),
        .beam_x              (beam_x),
        .beam_y              (beam_y)
    );

    always #10 clk_dot4x = !clk_dot4x;

    task automatic expect_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            $display("MISMATCH time=%0t %s expected=%0d actual=%0d",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // setup cycle, then access cycle sampled mid-clock
    task automatic apb_transfer(input logic write, input logic [5:0] addr,
                                input logic [7:0] wdata, output logic [7:0] rdata,
                                output logic err);
        @(posedge clk_dot4x);
        #2;
        paddr  = addr;
        pwdata = wdata;
        pwrite = write;
        psel   = 1'b1;
        @(posedge clk_dot4x);
        #2;
        penable = 1'b1;
        @(negedge clk_dot4x);
        rdata = prdata;
        err   = pslverr;
        assert (pready) else begin
            $display("error at %0t: pready was low during an access cycle", $time);
            errors++;
        end
        @(posedge clk_dot4x);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // bits kept by each register, zero where nothing is mapped
    function automatic logic [7:0] reg_mask(input logic [5:0] addr);
        if (addr == REG_CTRL1) return 8'h60;
        if (addr == REG_CTRL2) return 8'h17;
        if (addr == REG_SPR_PRI || addr == REG_SPR_MMC) return 8'hFF;
        if (addr >= REG_EC && addr <= REG_SPR_COL7) return 8'h0F;
        return 8'h00;
    endfunction

    task automatic readback_sweep();
        logic [7:0] shadow [64];
        logic [7:0] rdata;
        logic       err;
        for (int a = 0; a < 64; a++) begin
            shadow[a] = 8'($urandom);
            apb_transfer(1'b1, 6'(a), shadow[a], rdata, err);
            expect_value("pslverr", int'(reg_mask(6'(a)) == 8'h00), int'(err));
        end
        // unmapped writes above must not have touched any register
        for (int a = 0; a < 64; a++) begin
            apb_transfer(1'b0, 6'(a), 8'h00, rdata, err);
            expect_value("pslverr", int'(reg_mask(6'(a)) == 8'h00), int'(err));
            expect_value("prdata", int'(shadow[a] & reg_mask(6'(a))), int'(rdata));
        end
    endtask

    function automatic vic_color_t pick_color(input logic [1:0] sel, input vic_color_t c0,
                                              input vic_color_t c1, input vic_color_t c2,
                                              input vic_color_t c3);
        case (sel)
            2'b00:   return c0;
            2'b01:   return c1;
            2'b10:   return c2;
            default: return c3;
        endcase
    endfunction

    // expected color of a uniform pattern inside the window
    function automatic vic_color_t pixel_model(input mode_cfg_t m, input palette_cfg_t p,
                                               input sprite_cfg_t s, input logic [7:0] pix,
                                               input logic [11:0] chr,
                                               input logic [NUM_SPRITES-1:0][1:0] spr);
        display_mode_t md;
        vic_color_t    fg;
        vic_color_t    c;
        md = display_mode_t'({m.ecm, m.bmm, m.mcm});
        fg = vic_color_t'(chr[11:8]);
        case (md)
            MODE_STANDARD_CHAR:
                c = pix[7] ? fg : p.b0c;
            MODE_MULTICOLOR_CHAR:
                if (chr[11]) begin
                    c = pick_color(pix[7:6], p.b0c, p.b1c, p.b2c,
                                   vic_color_t'({1'b0, chr[10:8]}));
                end else begin
                    c = pix[7] ? fg : p.b0c;
                end
            MODE_STANDARD_BITMAP:
                c = pix[7] ? vic_color_t'(chr[7:4]) : vic_color_t'(chr[3:0]);
            MODE_MULTICOLOR_BITMAP:
                c = pick_color(pix[7:6], p.b0c, vic_color_t'(chr[7:4]),
                               vic_color_t'(chr[3:0]), fg);
            MODE_EXTENDED_BG_COLOR:
                c = pix[7] ? fg : pick_color(chr[7:6], p.b0c, p.b1c, p.b2c, p.b3c);
            default:
                c = BLACK;
        endcase
        // sprite 0 is applied last so it ends up on top
        for (int n = NUM_SPRITES - 1; n >= 0; n--) begin
            if (!s.pri[n] || !pix[7]) begin
                if (s.mmc[n] && spr[n] == 2'b01) begin
                    c = s.mc0;
                end else if (s.mmc[n] && spr[n] == 2'b11) begin
                    c = s.mc1;
                end else if (spr[n][1]) begin
                    c = s.col[n];
                end
            end
        end
        return c;
    endfunction

    task automatic program_image(input mode_cfg_t m, input palette_cfg_t p,
                                 input sprite_cfg_t s);
        logic [7:0] rdata;
        logic       err;
        apb_transfer(1'b1, REG_CTRL1, {1'b0, m.ecm, m.bmm, 5'b0}, rdata, err);
        apb_transfer(1'b1, REG_CTRL2, {3'b0, m.mcm, 1'b0, m.xscroll}, rdata, err);
        apb_transfer(1'b1, REG_SPR_PRI, s.pri, rdata, err);
        apb_transfer(1'b1, REG_SPR_MMC, s.mmc, rdata, err);
        apb_transfer(1'b1, REG_EC, {4'b0, p.ec}, rdata, err);
        apb_transfer(1'b1, REG_B0C, {4'b0, p.b0c}, rdata, err);
        apb_transfer(1'b1, REG_B1C, {4'b0, p.b1c}, rdata, err);
        apb_transfer(1'b1, REG_B2C, {4'b0, p.b2c}, rdata, err);
        apb_transfer(1'b1, REG_B3C, {4'b0, p.b3c}, rdata, err);
        apb_transfer(1'b1, REG_SPR_MC0, {4'b0, s.mc0}, rdata, err);
        apb_transfer(1'b1, REG_SPR_MC1, {4'b0, s.mc1}, rdata, err);
        for (int n = 0; n < NUM_SPRITES; n++) begin
            apb_transfer(1'b1, 6'(REG_SPR_COL0 + n), {4'b0, s.col[n]}, rdata, err);
        end
    endtask

    task automatic wait_line_start();
        @(negedge clk_dot4x);
        while (beam_x != 9'(LINE_DOTS - 1)) @(negedge clk_dot4x);
        while (beam_x != 9'd0) @(negedge clk_dot4x);
    endtask

    // one line of samples, skipping the dots near the border edges
    task automatic scan_line(input vic_color_t inner_color, input vic_color_t edge_color,
                             input logic bg);
        int x;
        int y;
        int first_y;
        int dot;
        first_y = int'(beam_y);
        for (int k = 1; k <= LINE_DOTS * 4; k++) begin
            @(negedge clk_dot4x);
            // four clocks per dot and the last sample falls on the next line
            dot = k / 4;
            x   = dot % LINE_DOTS;
            y   = (first_y + dot / LINE_DOTS) % LINE_COUNT;
            expect_value("beam_x", x, int'(beam_x));
            expect_value("beam_y", y, int'(beam_y));
            if (y < BORDER_TOP || y >= BORDER_BOTTOM ||
                x < BORDER_LEFT - 4 || x >= BORDER_RIGHT + 4) begin
                expect_value("pixel_color", int'(edge_color), int'(pixel_color));
            end else if (x >= BORDER_LEFT + 4 && x < BORDER_RIGHT - 4) begin
                expect_value("pixel_color", int'(inner_color), int'(pixel_color));
                expect_value("is_background_pixel", int'(bg), int'(is_background_pixel));
            end
        end
    endtask

    // index % 4 picks the kind
    // kind 0 legal modes, 1 illegal modes, 2 random sprites, 3 all sprites stacked
    task automatic run_scenario(input int index);
        logic [7:0]                  patterns [4];
        mode_cfg_t                   m;
        palette_cfg_t                p;
        sprite_cfg_t                 s;
        logic [2:0]                  mb;
        logic [7:0]                  pix;
        logic [11:0]                 chr;
        logic [NUM_SPRITES-1:0][1:0] spr;
        logic                        multicolor;
        vic_color_t                  expected;
        int                          kind;
        int                          line;
        patterns = '{8'h00, 8'hFF, 8'h55, 8'hAA};
        kind = index % 4;
        // the plain mode scenarios step through every mode of their group
        if (kind == 0) begin
            mb = 3'((index / 4) % 5);
        end else if (kind == 1) begin
            mb = 3'(5 + (index / 4) % 3);
        end else begin
            mb = 3'($urandom_range(4, 0));
        end
        m.ecm     = mb[2];
        m.bmm     = mb[1];
        m.mcm     = mb[0];
        m.xscroll = 3'($urandom);
        p   = palette_cfg_t'(20'($urandom));
        s   = sprite_cfg_t'(56'({$urandom, $urandom}));
        chr = 12'($urandom);
        // alternating bit patterns are only uniform in pixel pairs
        multicolor = m.mcm && (m.bmm || m.ecm || chr[11]);
        pix = multicolor ? patterns[$urandom_range(3, 0)] : patterns[$urandom_range(1, 0)];
        if (kind == 2) begin
            spr = 16'($urandom);
        end else if (kind == 3) begin
            spr = {NUM_SPRITES{2'b10}};
        end else begin
            spr = '0;
        end
        expected = pixel_model(m, p, s, pix, chr, spr);
        program_image(m, p, s);
        pixels_read   = pix;
        char_read     = chr;
        sprite_pixels = spr;
        wait_line_start();
        wait_line_start();
        // lines in the top or bottom border show only ec so keep going to an inner line
        do begin
            line = int'(beam_y);
            scan_line(expected, p.ec, !pix[7]);
        end while (line < BORDER_TOP || line >= BORDER_BOTTOM);
    endtask

    initial begin
        clk_dot4x     = 1'b0;
        rst           = 1'b1;
        paddr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = '0;
        pixels_read   = '0;
        char_read     = '0;
        sprite_pixels = '0;
        checks        = 0;
        errors        = 0;
        void'($urandom(35467));
        repeat (16) @(posedge clk_dot4x);
        #2;
        rst = 1'b0;
        @(negedge clk_dot4x);
        expect_value("pixel_color", int'(BLACK), int'(pixel_color));
        expect_value("is_background_pixel", 1, int'(is_background_pixel));
        expect_value("beam_x", 0, int'(beam_x));
        expect_value("beam_y", 0, int'(beam_y));
        readback_sweep();
        for (int i = 0; i < NUM_SCENARIOS; i++) begin
            run_scenario(i);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CLOCKS) @(posedge clk_dot4x);
        $display("timeout: the run did not finish within %0d clocks", WATCHDOG_CLOCKS);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/beam_counter.sv
`timescale 1ns/100ps
`default_nettype none

module beam_counter
    import vic_pkg::*;
#(
    parameter int LINE_DOTS     = 64,
    parameter int LINE_COUNT    = 16,
    parameter int BORDER_LEFT   = 8,
    parameter int BORDER_RIGHT  = 56,
    parameter int BORDER_TOP    = 2,
    parameter int BORDER_BOTTOM = 14
)
(
    input  wire logic  clk_dot4x,
    input  wire logic  rst,
    output dot_timing_t timing,
    output border_t     border,
    output logic [8:0]  beam_x,
    output logic [8:0]  beam_y
);

    logic [1:0] phase;
    logic [1:0] dot_in_half;
    logic       dot_advance;
    logic       dot_rising_0;
    logic       clk_phi;
    logic       phi_phase_start_15;

    // dot position moves at the end of phase 3
    assign dot_advance = (phase == 2'd3);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase              <= '0;
            dot_in_half        <= '0;
            dot_rising_0       <= 1'b0;
            clk_phi            <= 1'b0;
            phi_phase_start_15 <= 1'b0;
            beam_x             <= '0;
            beam_y             <= '0;
        end else begin
            phase              <= phase + 2'd1;
            dot_rising_0       <= dot_advance;
            // last clock of a 16 clock phi half
            phi_phase_start_15 <= (phase == 2'd2) && (dot_in_half == 2'd3);
            if (dot_advance) begin
                dot_in_half <= dot_in_half + 2'd1;
                if (dot_in_half == 2'd3) begin
                    clk_phi <= !clk_phi;
                end
                if (beam_x == 9'(LINE_DOTS - 1)) begin
                    beam_x <= '0;
                    beam_y <= (beam_y == 9'(LINE_COUNT - 1)) ? '0 : beam_y + 9'd1;
                end else begin
                    beam_x <= beam_x + 9'd1;
                end
            end
        end
    end

    // one clock behind the counters
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            border <= '0;
        end else begin
            border.left_right_border <= (beam_x < 9'(BORDER_LEFT)) ||
                                        (beam_x >= 9'(BORDER_RIGHT));
            border.top_bot_border    <= (beam_y < 9'(BORDER_TOP)) ||
                                        (beam_y >= 9'(BORDER_BOTTOM));
        end
    end

    assign timing = '{
        dot_rising_0:       dot_rising_0,
        clk_phi:            clk_phi,
        phi_phase_start_15: phi_phase_start_15,
        xpos_mod_8:         beam_x[2:0]
    };

    phi_start_on_phase_3: assert property (
        @(posedge clk_dot4x) disable iff (rst) phi_phase_start_15 |-> phase == 2'd3
    );

endmodule

`default_nettype wire

// File: source/pixel_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_sequencer
    import vic_pkg::*;
#(
    parameter int DATA_PIXEL_DELAY = 2
)
(
    input  wire logic         clk_dot4x,
    input  wire logic         rst,
    input  wire dot_timing_t  timing,
    input  wire border_t      border,
    input  wire mode_cfg_t    mode_cfg,
    input  wire palette_cfg_t palette_cfg,
    input  wire sprite_cfg_t  sprite_cfg,
    input  wire logic [7:0]   pixels_read,
    input  wire logic [11:0]  char_read,
    input  wire logic [NUM_SPRITES-1:0][1:0] sprite_pixels,
    output logic              is_background_pixel,
    output vic_color_t        pixel_color
);

    logic [7:0]  pixels_delayed  [DATA_PIXEL_DELAY+1];
    logic [11:0] char_delayed    [DATA_PIXEL_DELAY+1];
    logic [2:0]  xscroll_delayed [DATA_PIXEL_DELAY+1];
    logic [NUM_SPRITES-1:0][1:0] sprite_pixels_d;

    logic [7:0]    pixels_shifting;
    logic [11:0]   char_shifting;
    logic          shift_pixels;
    logic          capture;
    logic          load_pixels;
    logic          ismc;
    logic          load_ismc;
    logic          is_background_pixel2;
    display_mode_t mode;
    vic_color_t    char_fg;
    vic_color_t    color1_next;
    vic_color_t    color2_next;
    vic_color_t    pixel_color1;
    vic_color_t    pixel_color2;

    assign mode    = display_mode_t'({mode_cfg.ecm, mode_cfg.bmm, mode_cfg.mcm});
    assign char_fg = vic_color_t'(char_shifting[11:8]);
    assign capture = !timing.clk_phi && timing.phi_phase_start_15;
    assign load_pixels = (timing.xpos_mod_8 == xscroll_delayed[DATA_PIXEL_DELAY]);

    // multicolor pixel pairs, for the running char and for the one being loaded
    assign ismc      = mode_cfg.mcm && (mode_cfg.bmm || mode_cfg.ecm || char_shifting[11]);
    assign load_ismc = mode_cfg.mcm &&
                       (mode_cfg.bmm || mode_cfg.ecm || char_delayed[DATA_PIXEL_DELAY][11]);

    // fetch data captured at the end of phi low, then aged one dot per stage
    always_ff @(posedge clk_dot4x) begin
        if (capture) begin
            pixels_delayed[0] <= pixels_read;
            char_delayed[0]   <= char_read;
        end
        if (timing.dot_rising_0) begin
            for (int n = DATA_PIXEL_DELAY; n > 0; n--) begin
                pixels_delayed[n] <= pixels_delayed[n-1];
                char_delayed[n]   <= char_delayed[n-1];
            end
            sprite_pixels_d <= sprite_pixels;
        end
    end

    // xscroll travels with its data so a mid-line change lands on the right char
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int n = 0; n <= DATA_PIXEL_DELAY; n++) begin
                xscroll_delayed[n] <= '0;
            end
        end else begin
            if (capture) begin
                xscroll_delayed[0] <= mode_cfg.xscroll;
            end
            if (timing.dot_rising_0) begin
                for (int n = DATA_PIXEL_DELAY; n > 0; n--) begin
                    xscroll_delayed[n] <= xscroll_delayed[n-1];
                end
            end
        end
    end

    // pixel shifter, one bit per dot or two bits every other dot
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            shift_pixels        <= 1'b0;
            pixels_shifting     <= '0;
            char_shifting       <= '0;
            is_background_pixel <= 1'b1;
        end else if (timing.dot_rising_0) begin
            if (load_pixels) begin
                pixels_shifting     <= pixels_delayed[DATA_PIXEL_DELAY];
                char_shifting       <= char_delayed[DATA_PIXEL_DELAY];
                shift_pixels        <= !load_ismc;
                is_background_pixel <= !pixels_delayed[DATA_PIXEL_DELAY][7];
            end else begin
                if (ismc) begin
                    shift_pixels <= !shift_pixels;
                end
                if (shift_pixels && ismc) begin
                    pixels_shifting     <= {pixels_shifting[5:0], 2'b00};
                    is_background_pixel <= !pixels_shifting[5];
                end else if (shift_pixels) begin
                    pixels_shifting     <= {pixels_shifting[6:0], 1'b0};
                    is_background_pixel <= !pixels_shifting[6];
                end
            end
        end
    end

    // stage 1 mode decode
    always_comb begin
        color1_next = BLACK;
        case (mode)
            MODE_STANDARD_CHAR:
                color1_next = pixels_shifting[7] ? char_fg : palette_cfg.b0c;
            MODE_MULTICOLOR_CHAR:
                if (char_shifting[11]) begin
                    case (pixels_shifting[7:6])
                        2'b00:   color1_next = palette_cfg.b0c;
                        2'b01:   color1_next = palette_cfg.b1c;
                        2'b10:   color1_next = palette_cfg.b2c;
                        default: color1_next = vic_color_t'({1'b0, char_shifting[10:8]});
                    endcase
                end else begin
                    color1_next = pixels_shifting[7] ? char_fg : palette_cfg.b0c;
                end
            MODE_STANDARD_BITMAP, MODE_INV_EXTENDED_BG_COLOR_STANDARD_BITMAP:
                color1_next = pixels_shifting[7] ? vic_color_t'(char_shifting[7:4]) :
                                                   vic_color_t'(char_shifting[3:0]);
            MODE_MULTICOLOR_BITMAP, MODE_INV_EXTENDED_BG_COLOR_MULTICOLOR_BITMAP:
                case (pixels_shifting[7:6])
                    2'b00:   color1_next = palette_cfg.b0c;
                    2'b01:   color1_next = vic_color_t'(char_shifting[7:4]);
                    2'b10:   color1_next = vic_color_t'(char_shifting[3:0]);
                    default: color1_next = char_fg;
                endcase
            MODE_EXTENDED_BG_COLOR:
                // background picked by the two top char code bits
                case ({pixels_shifting[7], char_shifting[7:6]})
                    3'b000:  color1_next = palette_cfg.b0c;
                    3'b001:  color1_next = palette_cfg.b1c;
                    3'b010:  color1_next = palette_cfg.b2c;
                    3'b011:  color1_next = palette_cfg.b3c;
                    default: color1_next = char_fg;
                endcase
            default: color1_next = BLACK;
        endcase
    end

    // stage 2, illegal modes go black, then sprites 7 down to 0 overwrite
    always_comb begin
        color2_next = pixel_color1;
        if (mode inside {MODE_INV_EXTENDED_BG_COLOR_MULTICOLOR_CHAR,
                         MODE_INV_EXTENDED_BG_COLOR_STANDARD_BITMAP,
                         MODE_INV_EXTENDED_BG_COLOR_MULTICOLOR_BITMAP}) begin
            color2_next = BLACK;
        end
        for (int n = NUM_SPRITES - 1; n >= 0; n--) begin
            if (!sprite_cfg.pri[n] || is_background_pixel2) begin
                if (sprite_cfg.mmc[n]) begin
                    case (sprite_pixels_d[n])
                        2'b01:   color2_next = sprite_cfg.mc0;
                        2'b10:   color2_next = sprite_cfg.col[n];
                        2'b11:   color2_next = sprite_cfg.mc1;
                        default: ;
                    endcase
                end else if (sprite_pixels_d[n][1]) begin
                    color2_next = sprite_cfg.col[n];
                end
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixel_color1         <= BLACK;
            is_background_pixel2 <= 1'b1;
        end else if (timing.dot_rising_0) begin
            pixel_color1         <= color1_next;
            // lines up with the sampled sprite pixels
            is_background_pixel2 <= is_background_pixel;
        end
    end

    // stage 2 and stage 3 border mask
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixel_color2 <= BLACK;
            pixel_color  <= BLACK;
        end else begin
            pixel_color2 <= color2_next;
            pixel_color  <= (border.left_right_border || border.top_bot_border) ?
                            palette_cfg.ec : pixel_color2;
        end
    end

    dot_strobe_single_clock: assert property (
        @(posedge clk_dot4x) disable iff (rst) timing.dot_rising_0 |=> !timing.dot_rising_0
    );

endmodule

`default_nettype wire

// File: source/vic_pkg.sv
`default_nettype none

package vic_pkg;

    // sprite count is fixed since the config types are sized by it
    localparam int NUM_SPRITES = 8;

    typedef enum logic [3:0] {
        BLACK, WHITE, RED, CYAN, PURPLE, GREEN, BLUE, YELLOW,
        ORANGE, BROWN, PINK, DARK_GREY, GREY, LIGHT_GREEN, LIGHT_BLUE, LIGHT_GREY
    } vic_color_t;

    // encoded as {ecm, bmm, mcm}
    typedef enum logic [2:0] {
        MODE_STANDARD_CHAR                          = 3'b000,
        MODE_MULTICOLOR_CHAR                        = 3'b001,
        MODE_STANDARD_BITMAP                        = 3'b010,
        MODE_MULTICOLOR_BITMAP                      = 3'b011,
        MODE_EXTENDED_BG_COLOR                      = 3'b100,
        MODE_INV_EXTENDED_BG_COLOR_MULTICOLOR_CHAR  = 3'b101,
        MODE_INV_EXTENDED_BG_COLOR_STANDARD_BITMAP  = 3'b110,
        MODE_INV_EXTENDED_BG_COLOR_MULTICOLOR_BITMAP = 3'b111
    } display_mode_t;

    typedef enum logic [5:0] {
        REG_CTRL1    = 6'h11,
        REG_CTRL2    = 6'h16,
        REG_SPR_PRI  = 6'h1B,
        REG_SPR_MMC  = 6'h1C,
        REG_EC       = 6'h20,
        REG_B0C      = 6'h21,
        REG_B1C      = 6'h22,
        REG_B2C      = 6'h23,
        REG_B3C      = 6'h24,
        REG_SPR_MC0  = 6'h25,
        REG_SPR_MC1  = 6'h26,
        REG_SPR_COL0 = 6'h27,
        REG_SPR_COL1 = 6'h28,
        REG_SPR_COL2 = 6'h29,
        REG_SPR_COL3 = 6'h2A,
        REG_SPR_COL4 = 6'h2B,
        REG_SPR_COL5 = 6'h2C,
        REG_SPR_COL6 = 6'h2D,
        REG_SPR_COL7 = 6'h2E
    } vic_reg_addr_t;

    typedef struct packed {
        logic       ecm;
        logic       bmm;
        logic       mcm;
        logic [2:0] xscroll;
    } mode_cfg_t;

    typedef struct packed {
        vic_color_t ec;
        vic_color_t b0c;
        vic_color_t b1c;
        vic_color_t b2c;
        vic_color_t b3c;
    } palette_cfg_t;

    typedef struct packed {
        logic [NUM_SPRITES-1:0] pri;
        logic [NUM_SPRITES-1:0] mmc;
        vic_color_t             mc0;
        vic_color_t             mc1;
        vic_color_t [NUM_SPRITES-1:0] col;
    } sprite_cfg_t;

    typedef struct packed {
        logic       dot_rising_0;
        logic       clk_phi;
        logic       phi_phase_start_15;
        logic [2:0] xpos_mod_8;
    } dot_timing_t;

    typedef struct packed {
        logic left_right_border;
        logic top_bot_border;
    } border_t;

endpackage

`default_nettype wire

// File: source/vic_regs.sv
`timescale 1ns/100ps
`default_nettype none

module vic_regs
    import vic_pkg::*;
(
    input  wire logic       clk_dot4x,
    input  wire logic       rst,
    input  wire logic [5:0] paddr,
    input  wire logic       psel,
    input  wire logic       penable,
    input  wire logic       pwrite,
    input  wire logic [7:0] pwdata,
    output logic [7:0]      prdata,
    output logic            pready,
    output logic            pslverr,
    output mode_cfg_t       mode_cfg,
    output palette_cfg_t    palette_cfg,
    output sprite_cfg_t     sprite_cfg
);

    logic       access;
    logic       mapped;
    logic       wr_en;
    logic [2:0] col_idx;

    assign access  = psel && penable;
    assign wr_en   = access && pwrite && mapped;
    assign pready  = access;
    assign pslverr = access && !mapped;

    // 0x27..0x2e map to sprite 0..7, low bits plus one wrap 7 onto 0
    assign col_idx = paddr[2:0] + 3'd1;

    // address decode and readback
    always_comb begin
        mapped = 1'b1;
        prdata = 8'h00;
        case (paddr)
            REG_CTRL1:   prdata = {1'b0, mode_cfg.ecm, mode_cfg.bmm, 5'b0};
            REG_CTRL2:   prdata = {3'b0, mode_cfg.mcm, 1'b0, mode_cfg.xscroll};
            REG_SPR_PRI: prdata = sprite_cfg.pri;
            REG_SPR_MMC: prdata = sprite_cfg.mmc;
            REG_EC:      prdata = {4'b0, palette_cfg.ec};
            REG_B0C:     prdata = {4'b0, palette_cfg.b0c};
            REG_B1C:     prdata = {4'b0, palette_cfg.b1c};
            REG_B2C:     prdata = {4'b0, palette_cfg.b2c};
            REG_B3C:     prdata = {4'b0, palette_cfg.b3c};
            REG_SPR_MC0: prdata = {4'b0, sprite_cfg.mc0};
            REG_SPR_MC1: prdata = {4'b0, sprite_cfg.mc1};
            REG_SPR_COL0, REG_SPR_COL1, REG_SPR_COL2, REG_SPR_COL3,
            REG_SPR_COL4, REG_SPR_COL5, REG_SPR_COL6, REG_SPR_COL7:
                prdata = {4'b0, sprite_cfg.col[col_idx]};
            default:     mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            mode_cfg    <= '0;
            palette_cfg <= '0;
            sprite_cfg  <= '0;
        end else if (wr_en) begin
            case (paddr)
                REG_CTRL1: begin
                    mode_cfg.ecm <= pwdata[6];
                    mode_cfg.bmm <= pwdata[5];
                end
                REG_CTRL2: begin
                    mode_cfg.mcm     <= pwdata[4];
                    mode_cfg.xscroll <= pwdata[2:0];
                end
                REG_SPR_PRI: sprite_cfg.pri  <= pwdata;
                REG_SPR_MMC: sprite_cfg.mmc  <= pwdata;
                REG_EC:      palette_cfg.ec  <= vic_color_t'(pwdata[3:0]);
                REG_B0C:     palette_cfg.b0c <= vic_color_t'(pwdata[3:0]);
                REG_B1C:     palette_cfg.b1c <= vic_color_t'(pwdata[3:0]);
                REG_B2C:     palette_cfg.b2c <= vic_color_t'(pwdata[3:0]);
                REG_B3C:     palette_cfg.b3c <= vic_color_t'(pwdata[3:0]);
                REG_SPR_MC0: sprite_cfg.mc0  <= vic_color_t'(pwdata[3:0]);
                REG_SPR_MC1: sprite_cfg.mc1  <= vic_color_t'(pwdata[3:0]);
                default:     sprite_cfg.col[col_idx] <= vic_color_t'(pwdata[3:0]);
            endcase
        end
    end

    // access cycle must come inside a selected transfer
    apb_enable_with_select: assert property (
        @(posedge clk_dot4x) disable iff (rst) penable |-> psel
    );

endmodule

`default_nettype wire

// File: source/vic_video_top.sv
`timescale 1ns/100ps
`default_nettype none

module vic_video_top
    import vic_pkg::*;
#(
    parameter int LINE_DOTS        = 64,
    parameter int LINE_COUNT       = 16,
    parameter int BORDER_LEFT      = 8,
    parameter int BORDER_RIGHT     = 56,
    parameter int BORDER_TOP       = 2,
    parameter int BORDER_BOTTOM    = 14,
    parameter int DATA_PIXEL_DELAY = 2
)
(
    input  wire logic        clk_dot4x,
    input  wire logic        rst,
    input  wire logic [5:0]  paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [7:0]  pwdata,
    output logic [7:0]       prdata,
    output logic             pready,
    output logic             pslverr,
    input  wire logic [7:0]  pixels_read,
    input  wire logic [11:0] char_read,
    input  wire logic [NUM_SPRITES-1:0][1:0] sprite_pixels,
    output vic_color_t       pixel_color,
    output logic             is_background_pixel,
    output logic [8:0]       beam_x,
    output logic [8:0]       beam_y
);

    mode_cfg_t    mode_cfg;
    palette_cfg_t palette_cfg;
    sprite_cfg_t  sprite_cfg;
    dot_timing_t  timing;
    border_t      border;

    vic_regs u_regs (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .mode_cfg    (mode_cfg),
        .palette_cfg (palette_cfg),
        .sprite_cfg  (sprite_cfg)
    );

    beam_counter #(
        .LINE_DOTS     (LINE_DOTS),
        .LINE_COUNT    (LINE_COUNT),
        .BORDER_LEFT   (BORDER_LEFT),
        .BORDER_RIGHT  (BORDER_RIGHT),
        .BORDER_TOP    (BORDER_TOP),
        .BORDER_BOTTOM (BORDER_BOTTOM)
    ) u_beam (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .timing    (timing),
        .border    (border),
        .beam_x    (beam_x),
        .beam_y    (beam_y)
    );

    pixel_sequencer #(
        .DATA_PIXEL_DELAY (DATA_PIXEL_DELAY)
    ) u_seq (
        .clk_dot4x           (clk_dot4x),
        .rst                 (rst),
        .timing              (timing),
        .border              (border),
        .mode_cfg            (mode_cfg),
        .palette_cfg         (palette_cfg),
        .sprite_cfg          (sprite_cfg),
        .pixels_read         (pixels_read),
        .char_read           (char_read),
        .sprite_pixels       (sprite_pixels),
        .is_background_pixel (is_background_pixel),
        .pixel_color         (pixel_color)
    );

endmodule

`default_nettype wire
